// File: common/mcntrl_pkg.sv
package mcntrl_pkg;

    // local 2-bit command code used inside the encoder ROM
    typedef enum logic [1:0] {
        ENC_NOP       = 2'd0,
        ENC_WRITE     = 2'd1,
        ENC_PRECHARGE = 2'd2,
        ENC_ACTIVATE  = 2'd3
    } enc_cmd_e;

    // RAS/CAS/WE in positive logic
    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,
        RCW_WRITE     = 3'd3,
        RCW_ACTIVATE  = 3'd4,
        RCW_PRECHARGE = 3'd5
    } rcw_e;

    typedef struct packed {
        logic [14:0] addr;       // row/column, or skip count and done flag on a NOP
        logic [2:0]  bank;
        rcw_e        rcw;
        logic        odt_en;
        logic        cke;        // kept 0
        logic        sel;        // half-cycle select
        logic        dq_en;      // DQ out of tristate
        logic        dqs_en;     // DQS out of tristate
        logic        dqs_toggle;
        logic        dci;        // kept 0
        logic        buf_wr;
        logic        buf_rd;     // pull next data from write buffer
        logic        nop;        // insert one NOP cycle after this word
        logic        buf_rst;    // buffer page advance
    } seq_word_t;

    localparam int CMD_PAUSE_BITS = 10; // skip count field width on NOP words
    localparam int CMD_DONE_BIT   = 10; // end of sequence flag on NOP words

    // AXI byte offsets
    localparam logic [3:0] REG_CTRL     = 4'h0;
    localparam logic [3:0] REG_BANK_ROW = 4'h4;
    localparam logic [3:0] REG_COL_NUM  = 4'h8;
    localparam logic [3:0] REG_STATUS   = 4'hc;

endpackage

// File: common/enc_req_if.sv
interface enc_req_if #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10
);
    logic [2:0]                bank;
    logic [ADDRESS_NUMBER-1:0] row;
    logic [COLADDR_NUMBER-4:0] start_col; // in units of 8 columns
    logic [5:0]                num128;    // bursts of 8, 0 acts as 1
    logic                      start;     // single pulse, fields stable with it

    modport master (output bank, row, start_col, num128, start);
    modport slave (input bank, row, start_col, num128, start);
endinterface

// File: design/axil_ctrl_regs.sv
module axil_ctrl_regs #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10
) (
    input  logic        rst,
    input  logic        clk,
    input  logic [3:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic [3:0]  s_wstrb,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [3:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    enc_req_if.master   req,
    input  logic        enc_busy,
    input  logic        seq_busy,
    input  logic        seq_done
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] bank_row_q;
    logic [31:0] col_num_q;
    logic [31:0] wmask;
    logic        start_q;
    logic        run_q;    // start issued, sequencer not finished yet
    logic        done_q;   // sticky
    logic        busy;
    logic        wr_hs;
    logic        rd_hs;
    logic        start_wr;

    assign busy      = start_q | run_q | enc_busy | seq_busy; // covers hand-off gaps too
    assign s_awready = s_awvalid & s_wvalid & ~s_bvalid;      // AW and W taken together
    assign s_wready  = s_awready;
    assign wr_hs     = s_awready;
    assign s_arready = ~s_rvalid;
    assign rd_hs     = s_arvalid & s_arready;
    assign s_rresp   = RESP_OKAY;
    assign start_wr  = wr_hs && (s_awaddr == mcntrl_pkg::REG_CTRL) && s_wstrb[0] && s_wdata[0];
    assign wmask     = {{8{s_wstrb[3]}}, {8{s_wstrb[2]}}, {8{s_wstrb[1]}}, {8{s_wstrb[0]}}};

    assign req.bank      = bank_row_q[18:16];
    assign req.row       = bank_row_q[ADDRESS_NUMBER-1:0];
    assign req.start_col = col_num_q[COLADDR_NUMBER-4:0];
    assign req.num128    = col_num_q[13:8];
    assign req.start     = start_q;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            bank_row_q <= '0;
            col_num_q  <= '0;
            start_q    <= 1'b0;
            run_q      <= 1'b0;
            done_q     <= 1'b0;
            s_bvalid   <= 1'b0;
            s_bresp    <= RESP_OKAY;
            s_rvalid   <= 1'b0;
        end else begin
            start_q <= start_wr & ~busy; // busy start is dropped
            if (wr_hs && (s_awaddr == mcntrl_pkg::REG_BANK_ROW))
                bank_row_q <= (bank_row_q & ~wmask) | (s_wdata & wmask);
            if (wr_hs && (s_awaddr == mcntrl_pkg::REG_COL_NUM))
                col_num_q <= (col_num_q & ~wmask) | (s_wdata & wmask);

            if (wr_hs) begin
                s_bvalid <= 1'b1;
                s_bresp  <= (start_wr && busy) ? RESP_SLVERR : RESP_OKAY;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end

            if (rd_hs)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;

            if (start_q)
                run_q <= 1'b1;
            else if (seq_done)
                run_q <= 1'b0;

            if (start_q)
                done_q <= 1'b0;  // next start clears done
            else if (seq_done)
                done_q <= 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (rd_hs) begin
            case (s_araddr)
                mcntrl_pkg::REG_BANK_ROW: s_rdata <= bank_row_q;
                mcntrl_pkg::REG_COL_NUM:  s_rdata <= col_num_q;
                mcntrl_pkg::REG_STATUS:   s_rdata <= {30'd0, done_q, busy};
                default:                  s_rdata <= '0; // ctrl reads as 0
            endcase
        end
    end

    // a new sequence never starts on top of a running one
    a_no_start_busy: assert property (@(posedge rst) disable iff (clk)
        req.start |-> !enc_busy && !seq_busy);

endmodule

// File: cmd_encod/cmd_encod_linear_wr.sv
module cmd_encod_linear_wr #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10
) (
    input  logic                  rst,
    input  logic                  clk,
    enc_req_if.slave              req,
    output mcntrl_pkg::seq_word_t enc_cmd,
    output logic                  enc_wr,
    output logic                  enc_done,
    output logic                  enc_busy
);
    typedef enum logic [3:0] {
        ST_ACT, ST_BUF, ST_WR0, ST_DQEN, ST_WRN, ST_TOG, ST_PAUSE1, ST_PRE, ST_PAUSE2, ST_DONE
    } step_e;

    typedef struct packed {
        logic                 done;
        logic                 buf_rst;
        logic [1:0]           skip;
        mcntrl_pkg::enc_cmd_e cmd;
        logic                 odt;
        logic                 sel;
        logic                 dq_en;
        logic                 dqs_en;
        logic                 dqs_toggle;
        logic                 buf_rd;
        logic                 nop;
    } rom_t;

    step_e                     step;
    step_e                     step_nxt;
    rom_t                      rom;
    logic                      run;
    logic [5:0]                cnt;    // writes still to emit
    logic [ADDRESS_NUMBER-1:0] row_q;
    logic [COLADDR_NUMBER-4:0] col_q;
    logic [2:0]                bank_q;
    mcntrl_pkg::seq_word_t     word;

    assign enc_busy = run | enc_wr;

    always_comb begin
        rom = '0;
        case (step)
            ST_ACT: rom.cmd = mcntrl_pkg::ENC_ACTIVATE;
            ST_BUF: rom.buf_rd = 1'b1;  // prefetch first data
            ST_WR0: begin
                rom.cmd    = mcntrl_pkg::ENC_WRITE;
                rom.sel    = 1'b1;
                rom.odt    = 1'b1;
                rom.buf_rd = 1'b1;
            end
            ST_DQEN: begin
                rom.dq_en  = 1'b1;
                rom.dqs_en = 1'b1;
            end
            ST_WRN: begin               // repeated n-1 times
                rom.cmd        = mcntrl_pkg::ENC_WRITE;
                rom.nop        = 1'b1;
                rom.dqs_toggle = 1'b1;
                rom.dq_en      = 1'b1;
                rom.dqs_en     = 1'b1;
                rom.odt        = 1'b1;
            end
            ST_TOG: begin
                rom.skip       = 2'd2;
                rom.dqs_toggle = 1'b1;
            end
            ST_PAUSE1: rom.skip = 2'd2;
            ST_PRE: begin
                rom.cmd     = mcntrl_pkg::ENC_PRECHARGE;
                rom.buf_rst = 1'b1;
            end
            ST_PAUSE2: rom.skip = 2'd2;
            default:   rom.done = 1'b1;
        endcase
    end

    always_comb begin
        case (step)
            ST_DQEN: step_nxt = (cnt != 6'd0) ? ST_WRN : ST_TOG; // n==1 skips the loop
            ST_WRN:  step_nxt = (cnt == 6'd1) ? ST_TOG : ST_WRN;
            ST_DONE: step_nxt = ST_DONE;
            default: step_nxt = step_e'(step + 4'd1);
        endcase
    end

    always_comb begin
        word            = '0;
        word.bank       = bank_q;
        word.odt_en     = rom.odt;
        word.sel        = rom.sel;
        word.dq_en      = rom.dq_en;
        word.dqs_en     = rom.dqs_en;
        word.dqs_toggle = rom.dqs_toggle;
        word.buf_rd     = rom.buf_rd;
        word.buf_rst    = rom.buf_rst;
        word.nop        = rom.nop;
        case (rom.cmd)
            mcntrl_pkg::ENC_NOP: begin          // addr carries skip and done
                word.rcw = mcntrl_pkg::RCW_NOP;
                word.addr[mcntrl_pkg::CMD_PAUSE_BITS-1:0] =
                    {{(mcntrl_pkg::CMD_PAUSE_BITS-2){1'b0}}, rom.skip};
                word.addr[mcntrl_pkg::CMD_DONE_BIT] = rom.done;
            end
            mcntrl_pkg::ENC_WRITE: begin
                word.rcw  = mcntrl_pkg::RCW_WRITE;
                word.addr = {{(ADDRESS_NUMBER-COLADDR_NUMBER){1'b0}}, col_q, 3'b000};
            end
            mcntrl_pkg::ENC_PRECHARGE: begin
                word.rcw  = mcntrl_pkg::RCW_PRECHARGE;
                word.addr = row_q;
            end
            default: begin
                word.rcw  = mcntrl_pkg::RCW_ACTIVATE;
                word.addr = row_q;
            end
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            run      <= 1'b0;
            step     <= ST_ACT;
            cnt      <= '0;
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            if (req.start) begin
                run  <= 1'b1;
                step <= ST_ACT;
                cnt  <= (req.num128 == 6'd0) ? 6'd1 : req.num128;
            end else if (run) begin
                step <= step_nxt;
                if (step == ST_WR0 || step == ST_WRN)
                    cnt <= cnt - 6'd1;
                if (step == ST_DONE)
                    run <= 1'b0;
            end
            enc_wr <= run;  // word of this step is registered alongside
            if (req.start)
                enc_done <= 1'b0;
            else if (enc_wr && !run)
                enc_done <= 1'b1;  // after last word
        end
    end

    always_ff @(posedge rst) begin
        if (req.start) begin
            row_q  <= req.row;
            col_q  <= req.start_col;
            bank_q <= req.bank;
        end
        enc_cmd <= word;
    end

    // words only follow a start two cycles earlier
    a_wr_after_start: assert property (@(posedge rst) disable iff (clk)
        $rose(enc_wr) |-> $past(req.start, 2));

endmodule

// File: design/cmd_seq_mem.sv
module cmd_seq_mem #(
    parameter int SEQ_DEPTH_LOG = 6
) (
    input  logic                     rst,
    input  logic                     clk,
    input  mcntrl_pkg::seq_word_t    enc_cmd,
    input  logic                     enc_wr,
    input  logic                     enc_done,
    input  logic [SEQ_DEPTH_LOG-1:0] rd_addr,
    output mcntrl_pkg::seq_word_t    rd_data,
    output logic                     seq_start
);
    mcntrl_pkg::seq_word_t    mem [2**SEQ_DEPTH_LOG];
    logic [SEQ_DEPTH_LOG-1:0] wr_ptr;
    logic                     done_d;
    logic                     done_rise;

    assign done_rise = enc_done & ~done_d;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr    <= '0;
            done_d    <= 1'b0;
            seq_start <= 1'b0;
        end else begin
            done_d    <= enc_done;
            seq_start <= done_rise;
            if (done_rise)
                wr_ptr <= '0;  // rearm, next sequence lands at 0
            else if (enc_wr)
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (enc_wr)
            mem[wr_ptr] <= enc_cmd;
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

    // last slot filled, another write would wrap over word 0
    a_no_overflow: assert property (@(posedge rst) disable iff (clk)
        enc_wr && (&wr_ptr) |=> !enc_wr);

endmodule

// File: design/cmd_sequencer.sv
module cmd_sequencer #(
    parameter int SEQ_DEPTH_LOG = 6
) (
    input  logic                     rst,
    input  logic                     clk,
    input  logic                     seq_start,
    output logic [SEQ_DEPTH_LOG-1:0] rd_addr,
    input  mcntrl_pkg::seq_word_t    rd_data,
    output logic                     seq_busy,
    output logic                     seq_done,
    output logic [14:0]              ddr_addr,
    output logic [2:0]               ddr_ba,
    output mcntrl_pkg::rcw_e         ddr_rcw,
    output logic                     ddr_odt,
    output logic                     ddr_dq_en,
    output logic                     ddr_dqs_en,
    output logic                     ddr_dqs_toggle,
    output logic                     ddr_buf_rd,
    output logic                     ddr_buf_rst,
    output logic                     ddr_cmd_valid
);
    typedef enum logic [2:0] {IDLE, FETCH, ISSUE, PAUSE, EXTRA_NOP} seq_state_e;

    seq_state_e                            state;
    seq_state_e                            nxt;
    mcntrl_pkg::seq_word_t                 hold_q;   // word kept through pause and NOP
    mcntrl_pkg::seq_word_t                 cur;
    logic [mcntrl_pkg::CMD_PAUSE_BITS-1:0] skip;
    logic [mcntrl_pkg::CMD_PAUSE_BITS-1:0] skip_cnt;
    logic                                  is_nop;
    logic                                  is_done;
    logic                                  issue;

    assign issue   = (state == ISSUE);
    assign cur     = issue ? rd_data : hold_q;
    assign is_nop  = (rd_data.rcw == mcntrl_pkg::RCW_NOP);
    assign is_done = is_nop && rd_data.addr[mcntrl_pkg::CMD_DONE_BIT];
    assign skip    = rd_data.addr[mcntrl_pkg::CMD_PAUSE_BITS-1:0];

    always_comb begin
        nxt = state;
        case (state)
            IDLE:  if (seq_start) nxt = FETCH;
            FETCH: nxt = ISSUE;  // wait out read latency
            ISSUE: begin
                if (is_done)
                    nxt = IDLE;
                else if (is_nop && skip != '0)
                    nxt = PAUSE;
                else if (rd_data.nop)
                    nxt = EXTRA_NOP;
                else
                    nxt = ISSUE;
            end
            PAUSE:     if (skip_cnt == 1) nxt = ISSUE;
            EXTRA_NOP: nxt = ISSUE;
            default:   nxt = IDLE;
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= IDLE;
            rd_addr  <= '0;
            skip_cnt <= '0;
            seq_done <= 1'b0;
        end else begin
            state    <= nxt;
            seq_done <= issue && is_done;
            if (state == IDLE && seq_start)
                rd_addr <= '0;
            else if (nxt == ISSUE)
                rd_addr <= rd_addr + 1'b1;  // prefetch the word after the one entering issue
            if (issue)
                skip_cnt <= skip;
            else if (state == PAUSE)
                skip_cnt <= skip_cnt - 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (issue)
            hold_q <= rd_data;
    end

    assign seq_busy       = (state != IDLE);
    assign ddr_rcw        = issue ? cur.rcw : mcntrl_pkg::RCW_NOP; // pause and extra NOP idle the bus
    assign ddr_cmd_valid  = issue && (cur.rcw != mcntrl_pkg::RCW_NOP);
    assign ddr_addr       = cur.addr;
    assign ddr_ba         = cur.bank;
    assign ddr_odt        = cur.odt_en;
    assign ddr_dq_en      = cur.dq_en;
    assign ddr_dqs_en     = cur.dqs_en;
    assign ddr_dqs_toggle = cur.dqs_toggle;
    assign ddr_buf_rd     = issue && cur.buf_rd;   // buffer strobes once per word
    assign ddr_buf_rst    = issue && cur.buf_rst;

endmodule

// File: design/mcntrl_top.sv
module mcntrl_top #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int SEQ_DEPTH_LOG  = 6
) (
    input  logic             rst,
    input  logic             clk,
    input  logic [3:0]       s_awaddr,
    input  logic             s_awvalid,
    output logic             s_awready,
    input  logic [31:0]      s_wdata,
    input  logic [3:0]       s_wstrb,
    input  logic             s_wvalid,
    output logic             s_wready,
    output logic [1:0]       s_bresp,
    output logic             s_bvalid,
    input  logic             s_bready,
    input  logic [3:0]       s_araddr,
    input  logic             s_arvalid,
    output logic             s_arready,
    output logic [31:0]      s_rdata,
    output logic [1:0]       s_rresp,
    output logic             s_rvalid,
    input  logic             s_rready,
    output logic [14:0]      ddr_addr,
    output logic [2:0]       ddr_ba,
    output mcntrl_pkg::rcw_e ddr_rcw,
    output logic             ddr_odt,
    output logic             ddr_dq_en,
    output logic             ddr_dqs_en,
    output logic             ddr_dqs_toggle,
    output logic             ddr_buf_rd,
    output logic             ddr_buf_rst,
    output logic             ddr_cmd_valid
);
    mcntrl_pkg::seq_word_t    enc_cmd;
    mcntrl_pkg::seq_word_t    rd_data;
    logic                     enc_wr;
    logic                     enc_done;
    logic                     enc_busy;
    logic [SEQ_DEPTH_LOG-1:0] rd_addr;
    logic                     seq_start;
    logic                     seq_busy;
    logic                     seq_done;

    enc_req_if #(.ADDRESS_NUMBER(ADDRESS_NUMBER), .COLADDR_NUMBER(COLADDR_NUMBER)) req_if ();

    axil_ctrl_regs #(.ADDRESS_NUMBER(ADDRESS_NUMBER), .COLADDR_NUMBER(COLADDR_NUMBER)) u_regs (
        .rst(rst), .clk(clk),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .req(req_if.master),
        .enc_busy(enc_busy), .seq_busy(seq_busy), .seq_done(seq_done)
    );

    cmd_encod_linear_wr #(
        .ADDRESS_NUMBER(ADDRESS_NUMBER),
        .COLADDR_NUMBER(COLADDR_NUMBER)
    ) u_enc (
        .rst(rst), .clk(clk), .req(req_if.slave),
        .enc_cmd(enc_cmd), .enc_wr(enc_wr), .enc_done(enc_done), .enc_busy(enc_busy)
    );

    cmd_seq_mem #(.SEQ_DEPTH_LOG(SEQ_DEPTH_LOG)) u_mem (
        .rst(rst), .clk(clk),
        .enc_cmd(enc_cmd), .enc_wr(enc_wr), .enc_done(enc_done),
        .rd_addr(rd_addr), .rd_data(rd_data), .seq_start(seq_start)
    );

    cmd_sequencer #(.SEQ_DEPTH_LOG(SEQ_DEPTH_LOG)) u_seq (
        .rst(rst), .clk(clk),
        .seq_start(seq_start), .rd_addr(rd_addr), .rd_data(rd_data),
        .seq_busy(seq_busy), .seq_done(seq_done),
        .ddr_addr(ddr_addr), .ddr_ba(ddr_ba), .ddr_rcw(ddr_rcw), .ddr_odt(ddr_odt),
        .ddr_dq_en(ddr_dq_en), .ddr_dqs_en(ddr_dqs_en), .ddr_dqs_toggle(ddr_dqs_toggle),
        .ddr_buf_rd(ddr_buf_rd), .ddr_buf_rst(ddr_buf_rst), .ddr_cmd_valid(ddr_cmd_valid)
    );

endmodule

// File: verif/tb_mcntrl.sv
module tb_mcntrl;

    localparam int ADDRESS_NUMBER  = 15;
    localparam int COLADDR_NUMBER  = 10;
    localparam int SEQ_DEPTH_LOG   = 6;
    localparam int WATCHDOG_MARGIN = 1500;       // cycles on top of the per-test budget
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct {
        logic [2:0]                bank;
        logic [ADDRESS_NUMBER-1:0] row;
        logic [6:0]                col;
        logic [5:0]                num128;
        int                        exp_writes;   // WRITE commands expected on the pins
        bit                        stall;        // hold BREADY/RREADY low for random gaps
    } test_t;

    typedef struct {
        mcntrl_pkg::rcw_e          rcw;
        logic [ADDRESS_NUMBER-1:0] addr;
        logic [2:0]                ba;
        logic                      buf_rst;
    } cmd_t;

    logic             rst;   // clock
    logic             clk;   // async reset, high
    logic [3:0]       s_awaddr;
    logic             s_awvalid;
    logic             s_awready;
    logic [31:0]      s_wdata;
    logic [3:0]       s_wstrb;
    logic             s_wvalid;
    logic             s_wready;
    logic [1:0]       s_bresp;
    logic             s_bvalid;
    logic             s_bready;
    logic [3:0]       s_araddr;
    logic             s_arvalid;
    logic             s_arready;
    logic [31:0]      s_rdata;
    logic [1:0]       s_rresp;
    logic             s_rvalid;
    logic             s_rready;
    logic [14:0]      ddr_addr;
    logic [2:0]       ddr_ba;
    mcntrl_pkg::rcw_e ddr_rcw;
    logic             ddr_odt;
    logic             ddr_dq_en;
    logic             ddr_dqs_en;
    logic             ddr_dqs_toggle;
    logic             ddr_buf_rd;
    logic             ddr_buf_rst;
    logic             ddr_cmd_valid;

    test_t tests[$];
    cmd_t  mon_q[$];    // every cycle with ddr_cmd_valid
    int    errors;
    int    odt_cycles;      // cycles each PHY control pin is high over one sequence
    int    dq_en_cycles;
    int    dqs_en_cycles;
    int    toggle_cycles;
    int    buf_rd_cycles;

    mcntrl_top #(
        .ADDRESS_NUMBER(ADDRESS_NUMBER),
        .COLADDR_NUMBER(COLADDR_NUMBER),
        .SEQ_DEPTH_LOG(SEQ_DEPTH_LOG)
    ) DUT (.*);

    initial begin
        rst = 1'b0;
        forever #10 rst = ~rst;
    end

    always @(negedge rst) begin   // outputs settled half a cycle after the edge
        if (!clk && ddr_cmd_valid)
            mon_q.push_back(cmd_t'{ddr_rcw, ddr_addr, ddr_ba, ddr_buf_rst});
        if (!clk && ddr_odt === 1'b1)
            odt_cycles++;
        if (!clk && ddr_dq_en === 1'b1)
            dq_en_cycles++;
        if (!clk && ddr_dqs_en === 1'b1)
            dqs_en_cycles++;
        if (!clk && ddr_dqs_toggle === 1'b1)
            toggle_cycles++;
        if (!clk && ddr_buf_rd === 1'b1)
            buf_rd_cycles++;
    end

    task automatic compare_rcw(input string name, input mcntrl_pkg::rcw_e got,
                               input mcntrl_pkg::rcw_e exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %s (%0d) expected %s (%0d)",
                     $time, name, got.name(), got, exp.name(), exp);
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDRESS_NUMBER-1:0] got,
                                input logic [ADDRESS_NUMBER-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_status(input string name, input logic [1:0] got,
                                  input logic [1:0] exp);
        if (got !== exp) begin   // bit 1 done, bit 0 busy
            errors++;
            $display("Fail at %0t: %s got done %b busy %b expected done %b busy %b",
                     $time, name, got[1], got[0], exp[1], exp[0]);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input bit stall,
                             output logic [1:0] resp);
        int gap;
        @(posedge rst);
        s_awaddr  <= addr;
        s_wdata   <= data;
        s_wstrb   <= 4'hf;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        @(negedge rst);
        while (!s_awready) @(negedge rst);   // handshake lands on the next edge
        if (!s_wready) begin
            errors++;
            $display("WREADY low at %0t while the write address was taken", $time);
        end
        @(posedge rst);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_bready  <= !stall;
        @(negedge rst);
        while (!s_bvalid) @(negedge rst);
        resp = s_bresp;
        if (stall) begin
            gap = $urandom_range(1, 6);
            repeat (gap) @(negedge rst);
            if (!s_bvalid) begin
                errors++;
                $display("BVALID dropped at %0t before BREADY was given", $time);
            end
            @(posedge rst);
            s_bready <= 1'b1;
        end
        @(posedge rst);
        s_bready <= 1'b0;
        @(negedge rst);
        if (s_bvalid) begin   // response must go out once
            errors++;
            $display("BVALID still high at %0t after the response was taken", $time);
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, input bit stall, output logic [31:0] data);
        int gap;
        @(posedge rst);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        @(negedge rst);
        while (!s_arready) @(negedge rst);
        @(posedge rst);
        s_arvalid <= 1'b0;
        s_rready  <= !stall;
        @(negedge rst);
        while (!s_rvalid) @(negedge rst);
        data = s_rdata;
        compare_resp("s_rresp", s_rresp, RESP_OKAY);
        if (stall) begin
            gap = $urandom_range(1, 6);
            repeat (gap) @(negedge rst);
            if (!s_rvalid || s_rdata !== data) begin
                errors++;
                $display("read data not held at %0t while RREADY was low", $time);
            end
            @(posedge rst);
            s_rready <= 1'b1;
        end
        @(posedge rst);
        s_rready <= 1'b0;
        @(negedge rst);
        if (s_rvalid) begin
            errors++;
            $display("RVALID still high at %0t after the data was taken", $time);
        end
    endtask

    // reference model: ACTIVATE, n WRITEs, PRECHARGE are the only non-NOP words of a page write
    task automatic check_commands(input test_t t);
        cmd_t exp_q[$];
        int   n;
        exp_q.push_back(cmd_t'{mcntrl_pkg::RCW_ACTIVATE, t.row, t.bank, 1'b0});
        for (n = 0; n < t.exp_writes; n++)
            exp_q.push_back(cmd_t'{mcntrl_pkg::RCW_WRITE, {5'd0, t.col, 3'd0}, t.bank, 1'b0});
        exp_q.push_back(cmd_t'{mcntrl_pkg::RCW_PRECHARGE, t.row, t.bank, 1'b1});
        compare_field("issued command count", mon_q.size(), exp_q.size());
        for (n = 0; n < exp_q.size() && n < mon_q.size(); n++) begin
            compare_rcw($sformatf("ddr_rcw[%0d]", n), mon_q[n].rcw, exp_q[n].rcw);
            if (exp_q[n].rcw != mcntrl_pkg::RCW_PRECHARGE)   // row or column address
                compare_addr($sformatf("ddr_addr[%0d]", n), mon_q[n].addr, exp_q[n].addr);
            compare_field($sformatf("ddr_ba[%0d]", n), mon_q[n].ba, exp_q[n].ba);
            compare_field($sformatf("ddr_buf_rst[%0d]", n), mon_q[n].buf_rst, exp_q[n].buf_rst);
        end
        // first WRITE one cycle, each further WRITE two with its trailing NOP
        compare_field("ddr_odt cycles", odt_cycles, 2 * t.exp_writes - 1);
        // DQ enable NOP one cycle, then the further WRITEs
        compare_field("ddr_dq_en cycles", dq_en_cycles, 2 * t.exp_writes - 1);
        compare_field("ddr_dqs_en cycles", dqs_en_cycles, 2 * t.exp_writes - 1);
        // further WRITEs, then the toggle NOP held over its skip of 2
        compare_field("ddr_dqs_toggle cycles", toggle_cycles, 2 * t.exp_writes + 1);
        compare_field("ddr_buf_rd cycles", buf_rd_cycles, 2);   // prefetch and first WRITE
    endtask

    function automatic test_t make_entry(input logic [5:0] num128, input int exp_writes,
                                         input bit stall);
        test_t t;
        t.bank       = 3'($urandom);
        t.row        = ADDRESS_NUMBER'($urandom);
        t.col        = 7'($urandom);
        t.num128     = num128;
        t.exp_writes = exp_writes;
        t.stall      = stall;
        return t;
    endfunction

    initial begin   // watchdog
        int limit;
        #1;   // table is filled at time 0
        limit = WATCHDOG_MARGIN;
        foreach (tests[i])
            limit += (tests[i].num128 + 20) * 4;
        repeat (limit) @(posedge rst);
        $display("timeout after %0d cycles, a handshake or the sequence never finished", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        test_t       t;
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          errs_before;
        int          failed_tests;
        clk       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        errors       = 0;
        failed_tests = 0;
        void'($urandom(32'h231abef3));
        tests.push_back(make_entry(6'd1, 1, 1'b0));   // shortest loop-free page
        tests.push_back(make_entry(6'd0, 1, 1'b1));   // zero acts as one burst
        tests.push_back(make_entry(6'd2, 2, 1'b0));
        tests.push_back(make_entry(6'd5, 5, 1'b1));
        tests.push_back(make_entry(6'd16, 16, 1'b1));
        tests.push_back(make_entry(6'd3, 3, 1'b0));
        repeat (8) @(posedge rst);
        clk <= 1'b0;

        foreach (tests[i]) begin
            t = tests[i];
            errs_before = errors;
            axi_write(mcntrl_pkg::REG_BANK_ROW, {13'd0, t.bank, 1'b0, t.row}, t.stall, resp);
            compare_resp("s_bresp", resp, RESP_OKAY);
            axi_write(mcntrl_pkg::REG_COL_NUM, {18'd0, t.num128, 1'b0, t.col}, t.stall, resp);
            compare_resp("s_bresp", resp, RESP_OKAY);
            axi_read(mcntrl_pkg::REG_BANK_ROW, t.stall, rdata);
            compare_field("bank_row readback", rdata, {13'd0, t.bank, 1'b0, t.row});
            axi_read(mcntrl_pkg::REG_COL_NUM, t.stall, rdata);
            compare_field("col_num readback", rdata, {18'd0, t.num128, 1'b0, t.col});
            axi_read(mcntrl_pkg::REG_STATUS, 1'b0, rdata);
            compare_status("status before start", rdata[1:0], (i == 0) ? 2'b00 : 2'b10);

            mon_q.delete();
            odt_cycles    = 0;
            dq_en_cycles  = 0;
            dqs_en_cycles = 0;
            toggle_cycles = 0;
            buf_rd_cycles = 0;
            axi_write(mcntrl_pkg::REG_CTRL, 32'd1, 1'b0, resp);
            compare_resp("s_bresp start", resp, RESP_OKAY);
            axi_read(mcntrl_pkg::REG_STATUS, 1'b0, rdata);
            compare_status("status while running", rdata[1:0], 2'b01);   // done cleared
            axi_write(mcntrl_pkg::REG_CTRL, 32'd1, 1'b0, resp);          // start on top
            compare_resp("s_bresp busy start", resp, RESP_SLVERR);

            axi_read(mcntrl_pkg::REG_STATUS, 1'b0, rdata);
            while (!rdata[1])
                axi_read(mcntrl_pkg::REG_STATUS, 1'b0, rdata);
            compare_status("status at end", rdata[1:0], 2'b10);
            check_commands(t);

            if (errors != errs_before)
                failed_tests++;
            $display("test %0d bank %0d row 0x%h col 0x%h num128 %0d stall %0d: %s",
                     i, t.bank, t.row, t.col, t.num128, t.stall,
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/mcntrl_pkg.sv
common/enc_req_if.sv
design/axil_ctrl_regs.sv
cmd_encod/cmd_encod_linear_wr.sv
design/cmd_seq_mem.sv
design/cmd_sequencer.sv
design/mcntrl_top.sv
verif/tb_mcntrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mcntrl -f verilog.f \
    -o tb_mcntrl && ./obj_dir/tb_mcntrl | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
